//--- Bender.yml
package:
  name: inv_ip

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/invPkg.sv
      - source/operandLoad.sv
      - source/euclidStage.sv
      - source/inverseNormalize.sv
      - source/invIp.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - tb/invIpChk.sv
      - tb/invIpTb.sv

//--- source/euclidStage.sv
`timescale 1ns/100ps

`include "inv_settings.svh"

module euclidStage import invPkg::*; #(
    // Final iteration takes its coefficient without a remainder check
    parameter bit lastStage = 1'b0
) (
    input  logic        clk,
    input  logic        arstN,
    input  euclidStateT stateIn,
    output euclidStateT stateOut
);

    localparam int W = `INV_WIDTH;

    logic [W-1:0]          quotient;
    logic [W-1:0]          remainder;
    // Wide enough for coefficient times quotient
    logic signed [2*W:0]   coefWide;
    logic signed [W-1:0]   newCoef;
    logic                  divByZero;
    logic                  hitOne;
    euclidStateT           nextState;

    // ==================================================
    // Division step
    // ==================================================

    // Zero divisor only after number one was reduced
    assign divByZero = (stateIn.divisor == '0);

    always_comb begin
        quotient  = '0;
        remainder = '0;
        if (!divByZero) begin
            quotient  = stateIn.dividend / stateIn.divisor;
            remainder = stateIn.dividend % stateIn.divisor;
        end
    end

    // Remainder one ends the algorithm
    assign hitOne = (remainder == W'(1));

    // ==================================================
    // Coefficient update
    // ==================================================

    // mqHigh - mqLow * q, quotient is unsigned so pad a zero sign bit
    always_comb begin
        coefWide = stateIn.mqHigh - stateIn.mqLow * $signed({1'b0, quotient});
    end

    // Only the low bits matter, the true value fits in W signed bits
    assign newCoef = coefWide[W-1:0];

    // ==================================================
    // Next state
    // ==================================================

    always_comb begin
        // Default: carry everything, valid included
        nextState = stateIn;

        if (!stateIn.found) begin
            if (divByZero) begin
                // Number one case
                // Result is fixed up in the normalize stage
                nextState.found = 1'b1;
            end else begin
                // Shift the remainder pair on
                nextState.dividend = stateIn.divisor;
                nextState.divisor  = remainder;
                // Shift the coefficient pair on
                nextState.mqHigh   = stateIn.mqLow;
                nextState.mqLow    = newCoef;

                // Early finish or forced capture at the end
                if (hitOne || lastStage) begin
                    nextState.found    = 1'b1;
                    nextState.mqResult = newCoef;
                end
            end
        end
    end

    // ==================================================
    // Stage register
    // ==================================================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stateOut <= '0;
        end else begin
            stateOut <= nextState;
        end
    end

endmodule

//--- source/invIp.sv
`timescale 1ns/100ps

`include "inv_settings.svh"

module invIp import invPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    // One-cycle strobe with the operands
    input  logic                  inValid,
    input  logic [`INV_WIDTH-1:0] in1,
    input  logic [`INV_WIDTH-1:0] in2,
    // One-cycle strobe with the result
    output logic                  outValid,
    output logic [`INV_WIDTH-1:0] outInv
);

    invOperandsT operands;

    // Index 0 is the load output, index INV_STAGES feeds normalize
    euclidStateT stageState [0:`INV_STAGES];

    // ==================================================
    // Operand load
    // ==================================================

    // Order unknown here, loadI picks prime and number
    assign operands.prime  = in1;
    assign operands.number = in2;

    operandLoad loadI (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .operands (operands),
        .state    (stageState[0])
    );

    // ==================================================
    // Euclid iterations
    // ==================================================

    // One registered iteration per stage
    // last one captures its coefficient unconditionally
    for (genvar idx = 0; idx < `INV_STAGES; idx++) begin : gStage
        euclidStage #(
            .lastStage (idx == `INV_STAGES - 1)
        ) stageI (
            .clk      (clk),
            .arstN    (arstN),
            .stateIn  (stageState[idx]),
            .stateOut (stageState[idx+1])
        );
    end

    // ==================================================
    // Normalize and output
    // ==================================================

    inverseNormalize normI (
        .clk      (clk),
        .arstN    (arstN),
        .state    (stageState[`INV_STAGES]),
        .outValid (outValid),
        .outInv   (outInv)
    );

endmodule

//--- source/invPkg.sv
`include "inv_settings.svh"

package invPkg;

    // ==================================================
    // Input operands
    // ==================================================

    // Raw pair as seen at the pins
    // Field names hold only after the load stage has sorted them
    typedef struct packed {
        logic [`INV_WIDTH-1:0] prime;
        logic [`INV_WIDTH-1:0] number;
    } invOperandsT;

    // ==================================================
    // Per-stage Euclid state
    // ==================================================

    typedef struct packed {
        // Modulus, kept for the final fold into range
        logic [`INV_WIDTH-1:0]        prime;
        // Value to invert, kept for the number-is-one case
        logic [`INV_WIDTH-1:0]        number;
        // Running remainder pair
        logic [`INV_WIDTH-1:0]        dividend;
        logic [`INV_WIDTH-1:0]        divisor;
        // Running coefficient pair, two's complement
        logic signed [`INV_WIDTH-1:0] mqHigh;
        logic signed [`INV_WIDTH-1:0] mqLow;
        // Set once the remainder has reached one
        logic                         found;
        // Coefficient captured at that point
        logic signed [`INV_WIDTH-1:0] mqResult;
        // Strobe riding along with the data
        logic                         valid;
    } euclidStateT;

endpackage

//--- source/inv_settings.svh
`ifndef INV_SETTINGS_SVH
`define INV_SETTINGS_SVH

// ==================================================
// Datapath width
// ==================================================

// Operand and result width in bits
`define INV_WIDTH 6

// ==================================================
// Pipeline depth
// ==================================================

// Euclid iterations, enough for any prime below 2**INV_WIDTH
`define INV_STAGES 6

// Strobe in to strobe out
// One load cycle, one per Euclid stage, one normalize cycle
`define INV_LATENCY (`INV_STAGES + 2)

`endif

//--- source/inverseNormalize.sv
`timescale 1ns/100ps

`include "inv_settings.svh"

module inverseNormalize import invPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  euclidStateT           state,
    output logic                  outValid,
    output logic [`INV_WIDTH-1:0] outInv
);

    localparam int W = `INV_WIDTH;

    logic [W-1:0] answer;

    // ==================================================
    // Final answer
    // ==================================================

    always_comb begin
        if (state.number == W'(1)) begin
            // Euclid never ran, inverse of one is one
            answer = W'(1);
        end else if (state.mqResult[W-1]) begin
            // Negative coefficient, fold into 1..prime-1
            answer = state.mqResult + state.prime;
        end else begin
            answer = state.mqResult;
        end
    end

    // ==================================================
    // Output registers
    // ==================================================

    // Strobe follows the pipeline valid bit
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= state.valid;
        end
    end

    // Result only moves on a strobe
    // holds between strobes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outInv <= '0;
        end else if (state.valid) begin
            outInv <= answer;
        end
    end

endmodule

//--- source/operandLoad.sv
`timescale 1ns/100ps

`include "inv_settings.svh"

module operandLoad import invPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        inValid,
    input  invOperandsT operands,
    output euclidStateT state
);

    localparam int W = `INV_WIDTH;

    logic [W-1:0] bigger;
    logic [W-1:0] smaller;
    euclidStateT  nextState;

    // ==================================================
    // Sort the pair
    // ==================================================

    // Larger operand is the modulus
    always_comb begin
        if (operands.prime > operands.number) begin
            bigger  = operands.prime;
            smaller = operands.number;
        end else begin
            bigger  = operands.number;
            smaller = operands.prime;
        end
    end

    // ==================================================
    // Initial Euclid state
    // ==================================================

    always_comb begin
        nextState          = '0;
        nextState.prime    = bigger;
        nextState.number   = smaller;
        // First division is prime by number
        nextState.dividend = bigger;
        nextState.divisor  = smaller;
        // Coefficients start at 0 and 1
        nextState.mqHigh   = '0;
        nextState.mqLow    = W'(1);
        nextState.found    = 1'b0;
        nextState.mqResult = '0;
        nextState.valid    = inValid;
    end

    // Load register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= '0;
        end else begin
            state <= nextState;
        end
    end

endmodule

//--- tb/invIpChk.sv
`timescale 1ns/100ps

`include "inv_settings.svh"

module invIpChk (
    input logic                  clk,
    input logic                  arstN,
    input logic                  inValid,
    input logic [`INV_WIDTH-1:0] in1,
    input logic [`INV_WIDTH-1:0] in2,
    input logic                  outValid,
    input logic [`INV_WIDTH-1:0] outInv
);

    localparam int latency = `INV_LATENCY;

    // Assertion failures, summed into the testbench verdict
    int failCount = 0;

    // Inverse rule straight from the definition
    // Larger operand is the modulus, result lies in 1..prime-1
    function automatic bit isInverse(
        input logic [`INV_WIDTH-1:0] a,
        input logic [`INV_WIDTH-1:0] b,
        input logic [`INV_WIDTH-1:0] inv
    );
        int prime;
        int number;
        prime  = (a > b) ? int'(a) : int'(b);
        number = (a > b) ? int'(b) : int'(a);
        if (inv < 1 || inv >= prime) begin
            return 1'b0;
        end
        return ((int'(inv) * number) % prime) == 1;
    endfunction

    // ==================================================
    // Strobe timing
    // ==================================================

    // Nothing comes out while reset is held
    quietInReset: assert property (@(posedge clk) !arstN |-> !outValid)
        else begin
            $error("outValid is high while arstN is asserted");
            failCount++;
        end

    // Each accepted pair shows up after the full pipeline depth
    strobeArrives: assert property (@(posedge clk) disable iff (!arstN)
        inValid |-> ##latency outValid)
        else begin
            $error("outValid missing %0d cycles after inValid", latency);
            failCount++;
        end

    // No output strobe without a matching input strobe
    noSpuriousOut: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(inValid, latency))
        else begin
            $error("outValid without inValid %0d cycles earlier", latency);
            failCount++;
        end

    // ==================================================
    // Result value
    // ==================================================

    resultIsInverse: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> isInverse($past(in1, latency), $past(in2, latency), outInv))
        else begin
            $error("outInv %0d is not the inverse for the pair sent earlier", outInv);
            failCount++;
        end

    // Result register holds between strobes
    resultHolds: assert property (@(posedge clk) disable iff (!arstN)
        !outValid |-> $stable(outInv))
        else begin
            $error("outInv changed while outValid is low");
            failCount++;
        end

endmodule

//--- tb/invIpTb.sv
`timescale 1ns/100ps

`include "inv_settings.svh"

module invIpTb;

    localparam int W          = `INV_WIDTH;
    localparam int latency    = `INV_LATENCY;
    localparam int numRandom  = 200;
    localparam int drainLimit = `INV_LATENCY + 16;

    // One pair in flight with an optional known answer
    typedef struct packed {
        logic [W-1:0] prime;
        logic [W-1:0] number;
        logic         hasExpect;
        logic [W-1:0] expected;
    } sentPairT;

    logic         clk;
    logic         arstN;
    logic         inValid;
    logic [W-1:0] in1;
    logic [W-1:0] in2;
    logic         outValid;
    logic [W-1:0] outInv;

    sentPairT sentQ[$];
    int       errors;
    int       checks;
    int       testsRun;
    int       testsFailed;
    int       testStartErrors;

    // Primes below 64
    int primes [18] = '{2, 3, 5, 7, 11, 13, 17, 19, 23, 29, 31, 37, 41, 43, 47, 53, 59, 61};

    invIp dut_i (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .in1      (in1),
        .in2      (in2),
        .outValid (outValid),
        .outInv   (outInv)
    );

    bind invIp invIpChk chkI (.*);

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // Reference and bookkeeping
    // ==================================================

    // Brute-force search over 1..prime-1
    function automatic int findInverse(input int prime, input int number);
        int result;
        result = -1;
        for (int k = 1; k < prime; k++) begin
            if ((k * number) % prime == 1) begin
                result = k;
            end
        end
        return result;
    endfunction

    function automatic int totalErrors();
        return errors + dut_i.chkI.failCount;
    endfunction

    task automatic startTest();
        testStartErrors = totalErrors();
    endtask

    task automatic endTest(input string name);
        int n;
        n = totalErrors() - testStartErrors;
        testsRun++;
        if (n != 0) begin
            testsFailed++;
        end
        $display("Test %-14s %s, %0d errors", name, (n == 0) ? "ok" : "bad", n);
    endtask

    // outValid must be low at this falling edge
    task automatic checkQuiet();
        if (outValid !== 1'b0) begin
            $display("Fail at %0t ns: outValid got %b expected 0", $time, outValid);
            errors++;
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    // Drive one pair for one cycle from a falling edge
    task automatic sendPair(
        input logic [W-1:0] a,
        input logic [W-1:0] b,
        input logic         hasExpect,
        input logic [W-1:0] expected
    );
        sentPairT pair;
        pair.prime     = (a > b) ? a : b;
        pair.number    = (a > b) ? b : a;
        pair.hasExpect = hasExpect;
        pair.expected  = expected;
        inValid = 1'b1;
        in1     = a;
        in2     = b;
        sentQ.push_back(pair);
        @(negedge clk);
    endtask

    // Stop strobing and wait until every pair has come out
    task automatic waitDrain(input string name);
        int cycles;
        cycles  = 0;
        inValid = 1'b0;
        while (sentQ.size() > 0 && cycles < drainLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (sentQ.size() > 0) begin
            $display("Timeout in %s: %0d results never came out", name, sentQ.size());
            errors++;
            sentQ.delete();
        end
        @(negedge clk);
    endtask

    // Result monitor samples settled outputs at the falling edge
    always @(negedge clk) begin
        sentPairT pair;
        int       want;
        if (arstN && outValid) begin
            if (sentQ.size() == 0) begin
                $display("Error at %0t ns: outValid rose with no pair in flight", $time);
                errors++;
            end else begin
                pair = sentQ.pop_front();
                want = findInverse(pair.prime, pair.number);
                checks++;
                if (pair.hasExpect && outInv !== pair.expected) begin
                    $display("Fail at %0t ns: outInv got %0d expected %0d (%0d mod %0d)",
                             $time, outInv, pair.expected, pair.number, pair.prime);
                    errors++;
                end else if (int'(outInv) != want) begin
                    $display("Fail at %0t ns: outInv got %0d expected %0d (%0d mod %0d)",
                             $time, outInv, want, pair.number, pair.prime);
                    errors++;
                end
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        int p;
        int n;
        int cycles;
        void'($urandom(32'h18137580));
        arstN       = 1'b0;
        inValid     = 1'b0;
        in1         = '0;
        in2         = '0;
        errors      = 0;
        checks      = 0;
        testsRun    = 0;
        testsFailed = 0;

        // Reset held 8 cycles with outValid low throughout and after
        startTest();
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            checkQuiet();
        end
        arstN = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checkQuiet();
        end
        endTest("resetQuiet");

        // Known answers with 3 and 7 in both input orders
        startTest();
        sendPair(6'd3, 6'd7, 1'b1, 6'd5);
        sendPair(6'd7, 6'd3, 1'b1, 6'd5);
        sendPair(6'd10, 6'd13, 1'b1, 6'd4);
        sendPair(6'd2, 6'd61, 1'b1, 6'd31);
        waitDrain("knownPairs");
        endTest("knownPairs");

        // Number one bypasses Euclid
        startTest();
        sendPair(6'd7, 6'd1, 1'b1, 6'd1);
        sendPair(6'd1, 6'd61, 1'b1, 6'd1);
        sendPair(6'd2, 6'd1, 1'b1, 6'd1);
        sendPair(6'd1, 6'd31, 1'b1, 6'd1);
        waitDrain("numberOne");
        endTest("numberOne");

        // Single strobes with falling edges counted up to the output strobe
        startTest();
        for (int t = 0; t < 2; t++) begin
            sendPair((t == 0) ? 6'd5 : 6'd47, (t == 0) ? 6'd11 : 6'd20, 1'b0, '0);
            inValid = 1'b0;
            cycles  = 1;
            while (!outValid && cycles < 2 * latency) begin
                @(negedge clk);
                cycles++;
            end
            if (!outValid) begin
                $display("Timeout in fixedLatency: no outValid after %0d cycles", cycles);
                errors++;
            end else if (cycles != latency) begin
                $display("Fail at %0t ns: outValid latency got %0d expected %0d",
                         $time, cycles, latency);
                errors++;
            end
            // Exactly one strobe per pair
            for (int i = 0; i < latency; i++) begin
                @(negedge clk);
                checkQuiet();
            end
            waitDrain("fixedLatency");
        end
        endTest("fixedLatency");

        // Back-to-back random pairs checked by the monitor for order and value
        startTest();
        for (int i = 0; i < numRandom; i++) begin
            p = primes[$urandom % 18];
            n = 1 + ($urandom % (p - 1));
            if ($urandom % 2) begin
                sendPair(p[W-1:0], n[W-1:0], 1'b0, '0);
            end else begin
                sendPair(n[W-1:0], p[W-1:0], 1'b0, '0);
            end
        end
        waitDrain("fullPipeline");
        endTest("fullPipeline");

        // Reset with four pairs in flight drops them all
        startTest();
        for (int i = 0; i < 4; i++) begin
            p = primes[1 + ($urandom % 17)];
            n = 1 + ($urandom % (p - 1));
            sendPair(p[W-1:0], n[W-1:0], 1'b0, '0);
        end
        inValid = 1'b0;
        arstN   = 1'b0;
        sentQ.delete();
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            checkQuiet();
        end
        arstN = 1'b1;
        for (int i = 0; i < latency + 4; i++) begin
            @(negedge clk);
            checkQuiet();
        end
        // Pipeline still usable afterwards
        sendPair(6'd5, 6'd11, 1'b1, 6'd9);
        waitDrain("resetMidFlight");
        endTest("resetMidFlight");

        $display("Summary: %0d tests, %0d failed, %0d checked, %0d errors, %0d assertion fails",
                 testsRun, testsFailed, checks, errors, dut_i.chkI.failCount);
        if (totalErrors() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/invPkg.sv
source/operandLoad.sv
source/euclidStage.sv
source/inverseNormalize.sv
source/invIp.sv
tb/invIpChk.sv
tb/invIpTb.sv
